//--- rtl/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

  // width of hcount and vcount
  localparam int CNT_W = 11;

  // 4 bits per colour channel
  localparam int RGB_W = 12;

  // visible area of the 800x600 mode
  localparam int H_ACTIVE = 800;
  localparam int V_ACTIVE = 600;

endpackage

`default_nettype wire

//--- rtl/game_pkg.sv
`default_nettype none

package game_pkg;

  // enemy chain
  localparam int ENEMY_COUNT   = 3;
  localparam int ENEMY_SIZE    = 32;
  localparam int ENEMY_SPACING = 64;

  // stage 0 red, stage 1 green, stage 2 blue
  localparam logic [0:ENEMY_COUNT-1][vga_timing_pkg::RGB_W-1:0] ENEMY_COLOR = {
    12'hf00,
    12'h0f0,
    12'h00f
  };

  // level range
  localparam int                 LEVEL_W   = 4;
  localparam logic [LEVEL_W-1:0] LEVEL_MIN = 4'd1;
  localparam logic [LEVEL_W-1:0] LEVEL_MAX = 4'd9;

  // formation motion
  localparam logic [vga_timing_pkg::CNT_W-1:0] FORM_X_MIN   = 11'd16;
  localparam logic [vga_timing_pkg::CNT_W-1:0] FORM_X_MAX   = 11'd600;
  localparam logic [vga_timing_pkg::CNT_W-1:0] FORM_Y_START = 11'd40;
  localparam logic [vga_timing_pkg::CNT_W-1:0] FORM_DROP    = 11'd16;

  // launch point of a dead enemy
  localparam logic [vga_timing_pkg::CNT_W-1:0] MISSILE_PARK = '1;

  // level controller states
  localparam logic ST_PLAY    = 1'b0;
  localparam logic ST_CLEARED = 1'b1;

endpackage

`default_nettype wire

//--- rtl/formation_mover.sv
`timescale 1ns/1ns
`default_nettype none

module formation_mover (
  input  logic                             pclk_i,
  input  logic                             rst_n_i,
  input  logic                             vblnk_i,
  input  logic [game_pkg::LEVEL_W-1:0]     level_i,
  output logic                             frame_tick_o,
  output logic [vga_timing_pkg::CNT_W-1:0] form_x_o,
  output logic [vga_timing_pkg::CNT_W-1:0] form_y_o
);

  import vga_timing_pkg::*;
  import game_pkg::*;

  logic             vblnk_q;
  logic             dir_right_q;
  logic [CNT_W-1:0] step;
  logic [CNT_W:0]   x_right;
  logic             hit_right;
  logic             hit_left;
  logic [CNT_W-1:0] x_nxt;
  logic [CNT_W-1:0] y_nxt;
  logic             dir_right_nxt;

  // vblank rising edge, tick comes out one cycle later
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vblnk_q      <= 1'b0;
      frame_tick_o <= 1'b0;
    end else begin
      vblnk_q      <= vblnk_i;
      frame_tick_o <= vblnk_i & ~vblnk_q;
    end
  end

  // step size follows the level
  assign step    = CNT_W'(level_i);
  assign x_right = {1'b0, form_x_o} + {1'b0, step};

  // limits checked before the move, so no wrap on the left side
  assign hit_right = x_right > (CNT_W + 1)'(FORM_X_MAX);
  assign hit_left  = form_x_o < (FORM_X_MIN + step);

  always_comb begin
    x_nxt         = form_x_o;
    y_nxt         = form_y_o;
    dir_right_nxt = dir_right_q;
    if (dir_right_q) begin
      if (hit_right) begin
        x_nxt         = FORM_X_MAX;
        y_nxt         = form_y_o + FORM_DROP;
        dir_right_nxt = 1'b0;
      end else begin
        x_nxt = x_right[CNT_W-1:0];
      end
    end else begin
      if (hit_left) begin
        x_nxt         = FORM_X_MIN;
        y_nxt         = form_y_o + FORM_DROP;
        dir_right_nxt = 1'b1;
      end else begin
        x_nxt = form_x_o - step;
      end
    end
  end

  // formation moves once per frame
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      form_x_o    <= FORM_X_MIN;
      form_y_o    <= FORM_Y_START;
      dir_right_q <= 1'b1;
    end else if (frame_tick_o) begin
      form_x_o    <= x_nxt;
      form_y_o    <= y_nxt;
      dir_right_q <= dir_right_nxt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/enemy_stage.sv
`timescale 1ns/1ns
`default_nettype none

module enemy_stage (
  input  logic                             pclk_i,
  input  logic                             rst_n_i,

  // pixel stream in
  input  logic [vga_timing_pkg::CNT_W-1:0] vcount_i,
  input  logic                             vsync_i,
  input  logic                             vblnk_i,
  input  logic [vga_timing_pkg::CNT_W-1:0] hcount_i,
  input  logic                             hsync_i,
  input  logic                             hblnk_i,
  input  logic [vga_timing_pkg::RGB_W-1:0] rgb_i,

  // top left corner of this enemy
  input  logic [vga_timing_pkg::CNT_W-1:0] origin_x_i,
  input  logic [vga_timing_pkg::CNT_W-1:0] origin_y_i,

  // player missile
  input  logic [vga_timing_pkg::CNT_W-1:0] xpos_missile_i,
  input  logic [vga_timing_pkg::CNT_W-1:0] ypos_missile_i,
  input  logic                             missile_on_i,

  input  logic                             revive_i,
  input  logic [vga_timing_pkg::RGB_W-1:0] color_i,

  // pixel stream out
  output logic [vga_timing_pkg::CNT_W-1:0] vcount_o,
  output logic                             vsync_o,
  output logic                             vblnk_o,
  output logic [vga_timing_pkg::CNT_W-1:0] hcount_o,
  output logic                             hsync_o,
  output logic                             hblnk_o,
  output logic [vga_timing_pkg::RGB_W-1:0] rgb_o,

  output logic                             alive_o,
  output logic [vga_timing_pkg::CNT_W-1:0] en_x_missile_o,
  output logic [vga_timing_pkg::CNT_W-1:0] en_y_missile_o
);

  import vga_timing_pkg::*;
  import game_pkg::*;

  logic [CNT_W:0] x_end;
  logic [CNT_W:0] y_end;
  logic           pix_visible;
  logic           pix_in_sq;
  logic           msl_in_sq;
  logic           hit;
  logic           paint;

  // one past the square's right and bottom edges
  assign x_end = {1'b0, origin_x_i} + (CNT_W + 1)'(ENEMY_SIZE);
  assign y_end = {1'b0, origin_y_i} + (CNT_W + 1)'(ENEMY_SIZE);

  assign pix_visible = (hcount_i < CNT_W'(H_ACTIVE)) && (vcount_i < CNT_W'(V_ACTIVE));

  assign pix_in_sq = (hcount_i >= origin_x_i) && ({1'b0, hcount_i} < x_end) &&
                     (vcount_i >= origin_y_i) && ({1'b0, vcount_i} < y_end);

  // missile test works on coordinates only, not on the beam
  assign msl_in_sq = (xpos_missile_i >= origin_x_i) && ({1'b0, xpos_missile_i} < x_end) &&
                     (ypos_missile_i >= origin_y_i) && ({1'b0, ypos_missile_i} < y_end);

  assign hit   = missile_on_i && alive_o && msl_in_sq;
  assign paint = alive_o && pix_visible && pix_in_sq;

  // one pipeline register per stage
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vcount_o <= '0;
      vsync_o  <= 1'b0;
      vblnk_o  <= 1'b0;
      hcount_o <= '0;
      hsync_o  <= 1'b0;
      hblnk_o  <= 1'b0;
      rgb_o    <= '0;
    end else begin
      vcount_o <= vcount_i;
      vsync_o  <= vsync_i;
      vblnk_o  <= vblnk_i;
      hcount_o <= hcount_i;
      hsync_o  <= hsync_i;
      hblnk_o  <= hblnk_i;
      rgb_o    <= paint ? color_i : rgb_i;
    end
  end

  // alive flag
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alive_o <= 1'b1;
    end else if (revive_i) begin
      alive_o <= 1'b1;
    end else if (hit) begin
      alive_o <= 1'b0;
    end
  end

  // launch point at the bottom middle of the square
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_x_missile_o <= MISSILE_PARK;
      en_y_missile_o <= MISSILE_PARK;
    end else if (alive_o) begin
      en_x_missile_o <= origin_x_i + CNT_W'(ENEMY_SIZE / 2);
      en_y_missile_o <= origin_y_i + CNT_W'(ENEMY_SIZE);
    end else begin
      en_x_missile_o <= MISSILE_PARK;
      en_y_missile_o <= MISSILE_PARK;
    end
  end

endmodule

`default_nettype wire

//--- rtl/level_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module level_ctrl (
  input  logic                             pclk_i,
  input  logic                             rst_n_i,
  input  logic [game_pkg::ENEMY_COUNT-1:0] alive_i,
  input  logic                             frame_tick_i,
  output logic                             revive_o,
  output logic [game_pkg::LEVEL_W-1:0]     level_o
);

  import game_pkg::*;

  logic               state_q;
  logic               state_nxt;
  logic               revive_nxt;
  logic [LEVEL_W-1:0] level_nxt;
  logic               wave_clear;

  // while revive is high the flags are still low, so that cycle is ignored
  assign wave_clear = (alive_i == '0) && !revive_o;

  always_comb begin
    state_nxt  = state_q;
    revive_nxt = 1'b0;
    level_nxt  = level_o;
    case (state_q)
      ST_PLAY: begin
        if (wave_clear) begin
          state_nxt = ST_CLEARED;
        end
      end
      ST_CLEARED: begin
        // wait for the next frame before the new wave
        if (frame_tick_i) begin
          state_nxt  = ST_PLAY;
          revive_nxt = 1'b1;
          if (level_o < LEVEL_MAX) begin
            level_nxt = level_o + 1'b1;
          end
        end
      end
      default: begin
        state_nxt = ST_PLAY;
      end
    endcase
  end

  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_PLAY;
      revive_o <= 1'b0;
      level_o  <= LEVEL_MIN;
    end else begin
      state_q  <= state_nxt;
      revive_o <= revive_nxt;
      level_o  <= level_nxt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/enemies.sv
`timescale 1ns/1ns
`default_nettype none

module enemies (
  input  logic                             pclk_i,
  input  logic                             rst_n_i,

  input  logic [vga_timing_pkg::CNT_W-1:0] vcount_i,
  input  logic                             vsync_i,
  input  logic                             vblnk_i,
  input  logic [vga_timing_pkg::CNT_W-1:0] hcount_i,
  input  logic                             hsync_i,
  input  logic                             hblnk_i,
  input  logic [vga_timing_pkg::RGB_W-1:0] rgb_i,

  input  logic [vga_timing_pkg::CNT_W-1:0] xpos_missile_i,
  input  logic [vga_timing_pkg::CNT_W-1:0] ypos_missile_i,
  input  logic                             missile_on_i,

  output logic [vga_timing_pkg::CNT_W-1:0] vcount_o,
  output logic                             vsync_o,
  output logic                             vblnk_o,
  output logic [vga_timing_pkg::CNT_W-1:0] hcount_o,
  output logic                             hsync_o,
  output logic                             hblnk_o,
  output logic [vga_timing_pkg::RGB_W-1:0] rgb_o,

  output logic [game_pkg::ENEMY_COUNT-1:0][vga_timing_pkg::CNT_W-1:0] en_x_missile_o,
  output logic [game_pkg::ENEMY_COUNT-1:0][vga_timing_pkg::CNT_W-1:0] en_y_missile_o,
  output logic [game_pkg::LEVEL_W-1:0]     level_o
);

  import vga_timing_pkg::*;
  import game_pkg::*;

  // stream between stages, entry 0 is the top input
  logic [ENEMY_COUNT:0][CNT_W-1:0] vcount_c;
  logic [ENEMY_COUNT:0]            vsync_c;
  logic [ENEMY_COUNT:0]            vblnk_c;
  logic [ENEMY_COUNT:0][CNT_W-1:0] hcount_c;
  logic [ENEMY_COUNT:0]            hsync_c;
  logic [ENEMY_COUNT:0]            hblnk_c;
  logic [ENEMY_COUNT:0][RGB_W-1:0] rgb_c;

  logic [ENEMY_COUNT-1:0][CNT_W-1:0] origin_x;
  logic [ENEMY_COUNT-1:0]            alive;
  logic [CNT_W-1:0]                  form_x;
  logic [CNT_W-1:0]                  form_y;
  logic                              frame_tick;
  logic                              revive;

  assign vcount_c[0] = vcount_i;
  assign vsync_c[0]  = vsync_i;
  assign vblnk_c[0]  = vblnk_i;
  assign hcount_c[0] = hcount_i;
  assign hsync_c[0]  = hsync_i;
  assign hblnk_c[0]  = hblnk_i;
  assign rgb_c[0]    = rgb_i;

  assign vcount_o = vcount_c[ENEMY_COUNT];
  assign vsync_o  = vsync_c[ENEMY_COUNT];
  assign vblnk_o  = vblnk_c[ENEMY_COUNT];
  assign hcount_o = hcount_c[ENEMY_COUNT];
  assign hsync_o  = hsync_c[ENEMY_COUNT];
  assign hblnk_o  = hblnk_c[ENEMY_COUNT];
  assign rgb_o    = rgb_c[ENEMY_COUNT];

  // frame tick taken from the raw input vblank
  formation_mover u_mover (
    .pclk_i       (pclk_i),
    .rst_n_i      (rst_n_i),
    .vblnk_i      (vblnk_i),
    .level_i      (level_o),
    .frame_tick_o (frame_tick),
    .form_x_o     (form_x),
    .form_y_o     (form_y)
  );

  for (genvar k = 0; k < ENEMY_COUNT; k++) begin : g_stage
    // enemies side by side, one spacing apart
    assign origin_x[k] = form_x + CNT_W'(k * ENEMY_SPACING);

    enemy_stage u_stage (
      .pclk_i         (pclk_i),
      .rst_n_i        (rst_n_i),
      .vcount_i       (vcount_c[k]),
      .vsync_i        (vsync_c[k]),
      .vblnk_i        (vblnk_c[k]),
      .hcount_i       (hcount_c[k]),
      .hsync_i        (hsync_c[k]),
      .hblnk_i        (hblnk_c[k]),
      .rgb_i          (rgb_c[k]),
      .origin_x_i     (origin_x[k]),
      .origin_y_i     (form_y),
      .xpos_missile_i (xpos_missile_i),
      .ypos_missile_i (ypos_missile_i),
      .missile_on_i   (missile_on_i),
      .revive_i       (revive),
      .color_i        (ENEMY_COLOR[k]),
      .vcount_o       (vcount_c[k+1]),
      .vsync_o        (vsync_c[k+1]),
      .vblnk_o        (vblnk_c[k+1]),
      .hcount_o       (hcount_c[k+1]),
      .hsync_o        (hsync_c[k+1]),
      .hblnk_o        (hblnk_c[k+1]),
      .rgb_o          (rgb_c[k+1]),
      .alive_o        (alive[k]),
      .en_x_missile_o (en_x_missile_o[k]),
      .en_y_missile_o (en_y_missile_o[k])
    );
  end

  level_ctrl u_level (
    .pclk_i       (pclk_i),
    .rst_n_i      (rst_n_i),
    .alive_i      (alive),
    .frame_tick_i (frame_tick),
    .revive_o     (revive),
    .level_o      (level_o)
  );

endmodule

`default_nettype wire

//--- test/enemies_properties.sv
`timescale 1ns/1ns
`default_nettype none

module enemies_properties (
  input logic                                                        pclk_i,
  input logic                                                        rst_n_i,
  input logic [vga_timing_pkg::CNT_W-1:0]                            vcount_in_i,
  input logic                                                        vsync_in_i,
  input logic                                                        vblnk_in_i,
  input logic [vga_timing_pkg::CNT_W-1:0]                            hcount_in_i,
  input logic                                                        hsync_in_i,
  input logic                                                        hblnk_in_i,
  input logic [vga_timing_pkg::CNT_W-1:0]                            vcount_out_i,
  input logic                                                        vsync_out_i,
  input logic                                                        vblnk_out_i,
  input logic [vga_timing_pkg::CNT_W-1:0]                            hcount_out_i,
  input logic                                                        hsync_out_i,
  input logic                                                        hblnk_out_i,
  input logic [game_pkg::ENEMY_COUNT-1:0]                            alive_i,
  input logic                                                        revive_i,
  input logic [game_pkg::LEVEL_W-1:0]                                level_i,
  input logic [game_pkg::ENEMY_COUNT-1:0][vga_timing_pkg::CNT_W-1:0] en_x_missile_i,
  input logic [game_pkg::ENEMY_COUNT-1:0][vga_timing_pkg::CNT_W-1:0] en_y_missile_i
);

  import game_pkg::*;

  // counts and syncs come out three stages later, only once three cycles out of reset
  a_stream_delay: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    $past(rst_n_i, 3) |->
      ({vcount_out_i, vsync_out_i, vblnk_out_i, hcount_out_i, hsync_out_i, hblnk_out_i} ==
       $past({vcount_in_i, vsync_in_i, vblnk_in_i, hcount_in_i, hsync_in_i, hblnk_in_i}, 3)))
    else $error("output stream is not the input stream delayed by three cycles");

  a_level_range: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    (level_i >= LEVEL_MIN) && (level_i <= LEVEL_MAX))
    else $error("level left its range");

  a_revive_pulse: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    revive_i |=> !revive_i)
    else $error("revive lasted more than one cycle");

  // launch point register trails the alive flag by one cycle
  for (genvar k = 0; k < ENEMY_COUNT; k++) begin : g_launch
    a_dead_parked: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
      !alive_i[k] |=> (en_x_missile_i[k] == MISSILE_PARK) && (en_y_missile_i[k] == MISSILE_PARK))
      else $error("launch point of dead enemy %0d is not parked", k);
  end

endmodule

bind enemies enemies_properties u_properties (
  .pclk_i         (pclk_i),
  .rst_n_i        (rst_n_i),
  .vcount_in_i    (vcount_i),
  .vsync_in_i     (vsync_i),
  .vblnk_in_i     (vblnk_i),
  .hcount_in_i    (hcount_i),
  .hsync_in_i     (hsync_i),
  .hblnk_in_i     (hblnk_i),
  .vcount_out_i   (vcount_o),
  .vsync_out_i    (vsync_o),
  .vblnk_out_i    (vblnk_o),
  .hcount_out_i   (hcount_o),
  .hsync_out_i    (hsync_o),
  .hblnk_out_i    (hblnk_o),
  .alive_i        (alive),
  .revive_i       (revive),
  .level_i        (level_o),
  .en_x_missile_i (en_x_missile_o),
  .en_y_missile_i (en_y_missile_o)
);

`default_nettype wire

//--- test/enemies_tb.sv
`timescale 1ns/1ns
`default_nettype none

module enemies_tb;

  import vga_timing_pkg::*;
  import game_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int PIPE_DEPTH  = ENEMY_COUNT;
  localparam int MOVE_FRAMES = 620;
  // movement frames take five cycles each, short tests add a few hundred
  localparam int TIMEOUT_CYCLES = 20000;

  logic                              pclk;
  logic                              rst_n;
  logic [CNT_W-1:0]                  vcount;
  logic                              vsync;
  logic                              vblnk;
  logic [CNT_W-1:0]                  hcount;
  logic                              hsync;
  logic                              hblnk;
  logic [RGB_W-1:0]                  rgb;
  logic [CNT_W-1:0]                  xpos_missile;
  logic [CNT_W-1:0]                  ypos_missile;
  logic                              missile_on;
  logic [CNT_W-1:0]                  vcount_out;
  logic                              vsync_out;
  logic                              vblnk_out;
  logic [CNT_W-1:0]                  hcount_out;
  logic                              hsync_out;
  logic                              hblnk_out;
  logic [RGB_W-1:0]                  rgb_out;
  logic [ENEMY_COUNT-1:0][CNT_W-1:0] en_x_missile;
  logic [ENEMY_COUNT-1:0][CNT_W-1:0] en_y_missile;
  logic [LEVEL_W-1:0]                level;

  // reference model
  int                 model_x;
  int                 model_y;
  bit                 model_dir_right;
  bit                 model_cleared;
  logic [LEVEL_W-1:0] model_level;
  logic [ENEMY_COUNT-1:0] model_alive;
  int                 bounce_count;
  int                 cycle_count;

  enemies DUT (
    .pclk_i         (pclk),
    .rst_n_i        (rst_n),
    .vcount_i       (vcount),
    .vsync_i        (vsync),
    .vblnk_i        (vblnk),
    .hcount_i       (hcount),
    .hsync_i        (hsync),
    .hblnk_i        (hblnk),
    .rgb_i          (rgb),
    .xpos_missile_i (xpos_missile),
    .ypos_missile_i (ypos_missile),
    .missile_on_i   (missile_on),
    .vcount_o       (vcount_out),
    .vsync_o        (vsync_out),
    .vblnk_o        (vblnk_out),
    .hcount_o       (hcount_out),
    .hsync_o        (hsync_out),
    .hblnk_o        (hblnk_out),
    .rgb_o          (rgb_out),
    .en_x_missile_o (en_x_missile),
    .en_y_missile_o (en_y_missile),
    .level_o        (level)
  );

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  always @(posedge pclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] actual,
                             input logic [CNT_W-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                          $time, name, actual, expected));
    end
  endtask

  task automatic check_rgb(input string name, input logic [RGB_W-1:0] actual,
                           input logic [RGB_W-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic check_level(input string name, input logic [LEVEL_W-1:0] actual,
                             input logic [LEVEL_W-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                          $time, name, actual, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                          $time, name, actual, expected));
    end
  endtask

  // inputs change a short delay after the rising edge
  task automatic next_cycle();
    @(posedge pclk);
    #DRIVE_DELAY;
  endtask

  task automatic send_pixel(input logic [CNT_W-1:0] h, input logic [CNT_W-1:0] v,
                            input logic [RGB_W-1:0] c, input logic [RGB_W-1:0] exp_c);
    logic hs;
    logic vs;
    logic hb;
    hs     = 1'($urandom);
    vs     = 1'($urandom);
    hb     = 1'($urandom);
    hcount = h;
    vcount = v;
    rgb    = c;
    hsync  = hs;
    vsync  = vs;
    hblnk  = hb;
    vblnk  = 1'b0;
    next_cycle();
    // different values right behind the pixel, so a short pipeline shows up
    hcount = ~h;
    vcount = ~v;
    rgb    = ~c;
    hsync  = ~hs;
    vsync  = ~vs;
    hblnk  = ~hb;
    repeat (PIPE_DEPTH - 1) next_cycle();
    check_count("hcount_o", hcount_out, h);
    check_count("vcount_o", vcount_out, v);
    check_flag("hsync_o", hsync_out, hs);
    check_flag("vsync_o", vsync_out, vs);
    check_flag("hblnk_o", hblnk_out, hb);
    check_flag("vblnk_o", vblnk_out, 1'b0);
    check_rgb("rgb_o", rgb_out, exp_c);
  endtask

  task automatic check_launch_points();
    int ox;
    for (int k = 0; k < ENEMY_COUNT; k++) begin
      ox = model_x + k * ENEMY_SPACING;
      if (model_alive[k]) begin
        check_count($sformatf("en_x_missile_o[%0d]", k), en_x_missile[k],
                    CNT_W'(ox + ENEMY_SIZE / 2));
        check_count($sformatf("en_y_missile_o[%0d]", k), en_y_missile[k],
                    CNT_W'(model_y + ENEMY_SIZE));
      end else begin
        check_count($sformatf("en_x_missile_o[%0d]", k), en_x_missile[k], MISSILE_PARK);
        check_count($sformatf("en_y_missile_o[%0d]", k), en_y_missile[k], MISSILE_PARK);
      end
    end
  endtask

  // one pixel inside, then one past the right and the bottom edge
  task automatic paint_check(input int k);
    int               ox;
    int               dx;
    int               dy;
    logic [RGB_W-1:0] c;
    ox = model_x + k * ENEMY_SPACING;
    dx = $urandom % ENEMY_SIZE;
    dy = $urandom % ENEMY_SIZE;
    c  = RGB_W'($urandom);
    send_pixel(CNT_W'(ox + dx), CNT_W'(model_y + dy), c, model_alive[k] ? ENEMY_COLOR[k] : c);
    c = RGB_W'($urandom);
    send_pixel(CNT_W'(ox + ENEMY_SIZE), CNT_W'(model_y), c, c);
    c = RGB_W'($urandom);
    send_pixel(CNT_W'(ox), CNT_W'(model_y + ENEMY_SIZE), c, c);
  endtask

  task automatic advance_model_frame();
    int step;
    step = int'(model_level);
    if (model_dir_right) begin
      if (model_x + step > int'(FORM_X_MAX)) begin
        model_x         = int'(FORM_X_MAX);
        model_y         = model_y + int'(FORM_DROP);
        model_dir_right = 1'b0;
        bounce_count    = bounce_count + 1;
      end else begin
        model_x = model_x + step;
      end
    end else if (model_x - step < int'(FORM_X_MIN)) begin
      model_x         = int'(FORM_X_MIN);
      model_y         = model_y + int'(FORM_DROP);
      model_dir_right = 1'b1;
      bounce_count    = bounce_count + 1;
    end else begin
      model_x = model_x - step;
    end
    // a cleared wave comes back on the frame after the last hit
    if (model_cleared) begin
      if (model_level < LEVEL_MAX) begin
        model_level = model_level + 1'b1;
      end
      model_alive   = '1;
      model_cleared = 1'b0;
    end
  endtask

  task automatic frame_pulse();
    vblnk = 1'b1;
    next_cycle();
    vblnk = 1'b0;
    repeat (4) next_cycle();
    advance_model_frame();
  endtask

  task automatic hit_enemy(input int k);
    xpos_missile = CNT_W'(model_x + k * ENEMY_SPACING + int'($urandom % ENEMY_SIZE));
    ypos_missile = CNT_W'(model_y + int'($urandom % ENEMY_SIZE));
    missile_on   = 1'b1;
    next_cycle();
    missile_on   = 1'b0;
    xpos_missile = '1;
    ypos_missile = '1;
    repeat (2) next_cycle();
    model_alive[k] = 1'b0;
    if (model_alive == '0) begin
      model_cleared = 1'b1;
    end
  endtask

  // stream registers stay zero while reset is held, even with a busy input
  task automatic test_reset();
    check_count("vcount_o", vcount_out, '0);
    check_count("hcount_o", hcount_out, '0);
    check_flag("vsync_o", vsync_out, 1'b0);
    check_flag("vblnk_o", vblnk_out, 1'b0);
    check_flag("hsync_o", hsync_out, 1'b0);
    check_flag("hblnk_o", hblnk_out, 1'b0);
    check_rgb("rgb_o", rgb_out, '0);
    rst_n = 1'b1;
    repeat (2) next_cycle();
    check_level("level_o", level, LEVEL_MIN);
    check_launch_points();
  endtask

  // rows from 200 down stay clear of the formation here
  task automatic test_pass_through();
    logic [RGB_W-1:0] c;
    for (int i = 0; i < 20; i++) begin
      c = RGB_W'($urandom);
      send_pixel(CNT_W'($urandom), CNT_W'(200 + $urandom % 1800), c, c);
    end
  endtask

  task automatic test_paint();
    for (int k = 0; k < ENEMY_COUNT; k++) begin
      repeat (3) paint_check(k);
    end
  endtask

  task automatic test_hit();
    hit_enemy(1);
    check_launch_points();
    paint_check(1);
    // missile over enemy 0, but not flying
    xpos_missile = CNT_W'(model_x + 8);
    ypos_missile = CNT_W'(model_y + 8);
    missile_on   = 1'b0;
    repeat (3) next_cycle();
    xpos_missile = '1;
    ypos_missile = '1;
    check_launch_points();
    paint_check(0);
  endtask

  task automatic test_wave_clear();
    hit_enemy(0);
    hit_enemy(2);
    check_launch_points();
    repeat (8) begin
      next_cycle();
      check_level("level_o", level, LEVEL_MIN);
    end
    frame_pulse();
    check_level("level_o", level, model_level);
    check_launch_points();
    for (int k = 0; k < ENEMY_COUNT; k++) begin
      paint_check(k);
    end
  endtask

  task automatic test_movement();
    repeat (MOVE_FRAMES) begin
      frame_pulse();
      check_launch_points();
    end
    check_level("level_o", level, model_level);
  endtask

  initial begin
    void'($urandom(32'h90b7));
    cycle_count     = 0;
    rst_n           = 1'b0;
    vcount          = 11'd300;
    vsync           = 1'b1;
    vblnk           = 1'b0;
    hcount          = 11'd300;
    hsync           = 1'b1;
    hblnk           = 1'b1;
    rgb             = 12'habc;
    xpos_missile    = '1;
    ypos_missile    = '1;
    missile_on      = 1'b0;
    model_x         = int'(FORM_X_MIN);
    model_y         = int'(FORM_Y_START);
    model_dir_right = 1'b1;
    model_cleared   = 1'b0;
    model_level     = LEVEL_MIN;
    model_alive     = '1;
    bounce_count    = 0;
    repeat (16) @(posedge pclk);
    #DRIVE_DELAY;

    test_reset();
    test_pass_through();
    test_paint();
    test_hit();
    test_wave_clear();
    test_movement();

    // movement has to reach both limits to count
    if (bounce_count < 2) begin
      abort_run("formation did not bounce at both limits during the movement test");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
rtl/vga_timing_pkg.sv
rtl/game_pkg.sv
rtl/formation_mover.sv
rtl/enemy_stage.sv
rtl/level_ctrl.sv
rtl/enemies.sv
test/enemies_properties.sv
test/enemies_tb.sv
